/* logic/tri_pkg.sv */
package tri_pkg;

	// Channel widths
	localparam int lin_width    = 7;
	localparam int period_width = 11;
	localparam int step_width   = 5;
	localparam int level_width  = 4;

	typedef logic [lin_width-1:0]    lin_count_t;  // Linear count and reload value
	typedef logic [period_width-1:0] period_t;     // Timer period
	typedef logic [step_width-1:0]   seq_step_t;   // Sequencer position
	typedef logic [level_width-1:0]  tri_level_t;  // DAC level

	// One CPU write byte, read differently by the linear and high period registers
	typedef union packed {
		struct packed {
			logic       ctrl;    // Halt bit, also length counter disable
			lin_count_t reload;
		} lin;
		struct packed {
			logic [4:0] length_idx;  // Length table index, not used by this channel
			logic [2:0] period_hi;   // Period bits 10..8
		} hi;
	} reg_data_u;

endpackage

/* logic/tri_linear_counter.sv */
`timescale 1ns/100ps

module tri_linear_counter (
	input  logic               phi1,
	input  logic               arst_n,
	input  logic               wr_lin,
	input  logic               wr_hi,
	input  logic               lfo,
	input  tri_pkg::reg_data_u data,
	output logic               length_enable,
	output logic               lin_active
);

	import tri_pkg::*;

	logic       ctrl_bit;
	lin_count_t reload_val;
	logic       reload_flag;
	lin_count_t count;
	logic       count_zero;

	assign count_zero = (count == '0);

	// Control bit from the linear register write
	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_bit <= 1'b0;
		end else if (wr_lin) begin
			ctrl_bit <= data.lin.ctrl;
		end
	end

	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			reload_val <= '0;
		end else if (wr_lin) begin
			reload_val <= data.lin.reload;
		end
	end

	// A period high write requests a reload.
	// With the control bit set the request stays, so every quarter frame reloads
	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			reload_flag <= 1'b0;
		end else if (wr_hi) begin
			reload_flag <= 1'b1;  // Wins over a clear in the same cycle
		end else if (lfo && !ctrl_bit) begin
			reload_flag <= 1'b0;
		end
	end

	// Quarter frame step, flag sampled before its own update
	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (lfo) begin
			if (reload_flag) begin
				count <= reload_val;
			end else if (!count_zero) begin
				count <= count - 1'b1;
			end
		end
	end

	assign lin_active    = !count_zero;
	assign length_enable = !ctrl_bit;  // Halt stops the length counter too

endmodule

/* logic/tri_period_timer.sv */
`timescale 1ns/100ps

module tri_period_timer (
	input  logic               phi1,
	input  logic               arst_n,
	input  logic               wr_lo,
	input  logic               wr_hi,
	input  tri_pkg::reg_data_u data,
	output logic               tick
);

	import tri_pkg::*;

	period_t period;
	period_t count;
	logic    count_zero;

	assign count_zero = (count == '0);

	// Period assembled from the low byte and the three high bits
	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			period <= '0;
		end else begin
			if (wr_lo) begin
				period[7:0] <= data;
			end
			if (wr_hi) begin
				period[period_width-1:8] <= data.hi.period_hi;
			end
		end
	end

	// Free running down counter.
	// New period values are only picked up here, at the zero reload
	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (count_zero) begin
			count <= period;
		end else begin
			count <= count - 1'b1;
		end
	end

	// One pulse per reload, so every period+1 cycles
	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			tick <= 1'b0;
		end else begin
			tick <= count_zero;
		end
	end

endmodule

/* logic/tri_sequencer.sv */
`timescale 1ns/100ps

module tri_sequencer (
	input  logic                phi1,
	input  logic                arst_n,
	input  logic                tick,
	input  logic                lin_active,
	input  logic                lock,
	input  logic                wr_step,
	input  tri_pkg::reg_data_u  data,
	output tri_pkg::tri_level_t tri_out
);

	import tri_pkg::*;

	seq_step_t  step;
	logic       step_en;
	logic       descending;
	tri_level_t low_nibble;

	// Timer tick only counts while the linear counter runs and the channel is free
	assign step_en = tick && lin_active && !lock;

	always_ff @(posedge phi1 or negedge arst_n) begin
		if (!arst_n) begin
			step <= '0;
		end else if (wr_step) begin
			step <= data[step_width-1:0];  // Debug preset
		end else if (step_en) begin
			step <= step + 1'b1;  // 31 wraps to 0
		end
	end

	// First half of the sequence falls, second half rises
	assign descending = !step[step_width-1];
	assign low_nibble = step[level_width-1:0];

	always_comb begin
		if (descending) begin
			tri_out = ~low_nibble;  // 15 - nibble
		end else begin
			tri_out = low_nibble;
		end
	end

endmodule

/* logic/tri_chan.sv */
`timescale 1ns/100ps

module tri_chan (
	input  logic                phi1,
	input  logic                arst_n,
	input  logic                wr_lin,
	input  logic                wr_lo,
	input  logic                wr_hi,
	input  logic                wr_step,
	input  tri_pkg::reg_data_u  data,
	input  logic                lfo,
	input  logic                lock,
	output tri_pkg::tri_level_t tri_out,
	output logic                length_enable
);

	logic lin_active;
	logic tick;

	tri_linear_counter i_lin_cnt (
		.phi1          (phi1),
		.arst_n        (arst_n),
		.wr_lin        (wr_lin),
		.wr_hi         (wr_hi),
		.lfo           (lfo),
		.data          (data),
		.length_enable (length_enable),
		.lin_active    (lin_active)
	);

	// Frequency divider
	tri_period_timer i_period_timer (
		.phi1   (phi1),
		.arst_n (arst_n),
		.wr_lo  (wr_lo),
		.wr_hi  (wr_hi),
		.data   (data),
		.tick   (tick)
	);

	tri_sequencer i_sequencer (
		.phi1       (phi1),
		.arst_n     (arst_n),
		.tick       (tick),
		.lin_active (lin_active),
		.lock       (lock),
		.wr_step    (wr_step),
		.data       (data),
		.tri_out    (tri_out)
	);

endmodule

/* verification/tri_chan_assert.sv */
`timescale 1ns/100ps

module tri_chan_assert (
	input logic                phi1,
	input logic                arst_n,
	input logic                tick,
	input logic                lin_active,
	input logic                lock,
	input logic                wr_step,
	input tri_pkg::reg_data_u  data,
	input tri_pkg::seq_step_t  step,
	input tri_pkg::tri_level_t tri_out
);

	import tri_pkg::*;

	int   fail_count = 0;
	logic qualified;

	assign qualified = tick && lin_active && !lock;  // Tick that may advance the step

	step_hold: assert property (@(posedge phi1) disable iff (!arst_n)
		(!wr_step && !qualified) |=> (step == $past(step)))
		else begin
			$error("step changed without a load or a qualified tick");
			fail_count = fail_count + 1;
		end

	step_inc: assert property (@(posedge phi1) disable iff (!arst_n)
		(!wr_step && qualified) |=> (step == seq_step_t'($past(step) + 1'b1)))
		else begin
			$error("step did not advance by one after a qualified tick");
			fail_count = fail_count + 1;
		end

	step_load: assert property (@(posedge phi1) disable iff (!arst_n)
		wr_step |=> (step == $past(data[step_width-1:0])))
		else begin
			$error("step preset was not loaded");
			fail_count = fail_count + 1;
		end

	// Falling half then rising half
	level_fold: assert property (@(posedge phi1) disable iff (!arst_n)
		tri_out == (step[4] ? step[3:0] : 4'd15 - step[3:0]))
		else begin
			$error("tri_out does not match the folded step");
			fail_count = fail_count + 1;
		end

endmodule

bind tri_sequencer tri_chan_assert i_seq_assert (
	.phi1       (phi1),
	.arst_n     (arst_n),
	.tick       (tick),
	.lin_active (lin_active),
	.lock       (lock),
	.wr_step    (wr_step),
	.data       (data),
	.step       (step),
	.tri_out    (tri_out)
);

/* verification/tri_chan_tb.sv */
`timescale 1ns/100ps

module tri_chan_tb;

	import tri_pkg::*;

	// One test row; name is up to 12 ASCII characters
	typedef struct packed {
		logic [95:0] name;
		period_t     period;
		logic        ctrl;
		lin_count_t  reload;
		logic [3:0]  lfo_pulses;
		logic        lock;
		seq_step_t   preset;
		logic [15:0] run_cycles;
		tri_level_t  exp_level;
		logic        exp_len_en;
	} row_t;

	logic       phi1;
	logic       arst_n;
	logic       wr_lin;
	logic       wr_lo;
	logic       wr_hi;
	logic       wr_step;
	logic       lfo;
	logic       lock;
	reg_data_u  data;
	tri_level_t tri_out;
	logic       length_enable;

	row_t rows [0:10];
	int   pass_count;
	int   fail_count;
	int   assert_fails;
	bit   test_ok;
	int   cycle_count = 0;
	int   cycle_limit = 0;

	tri_chan i_tri_chan (
		.phi1          (phi1),
		.arst_n        (arst_n),
		.wr_lin        (wr_lin),
		.wr_lo         (wr_lo),
		.wr_hi         (wr_hi),
		.wr_step       (wr_step),
		.data          (data),
		.lfo           (lfo),
		.lock          (lock),
		.tri_out       (tri_out),
		.length_enable (length_enable)
	);

	always #10 phi1 = ~phi1;

	// Run lengths are whole multiples of period+1, so the tick count is exact
	task automatic fill_table();
		//            name           period   ctrl  reload lfo   lock  preset run     level  len_en
		rows[0]  = '{"fold_s0",     11'd3,   1'b0, 7'd0,  4'd1, 1'b0, 5'd0,  16'd8,  4'd15, 1'b1};
		rows[1]  = '{"fold_s7",     11'd3,   1'b0, 7'd0,  4'd1, 1'b0, 5'd7,  16'd8,  4'd8,  1'b1};
		rows[2]  = '{"fold_s16",    11'd3,   1'b0, 7'd0,  4'd1, 1'b0, 5'd16, 16'd8,  4'd0,  1'b1};
		rows[3]  = '{"fold_s31",    11'd3,   1'b0, 7'd0,  4'd1, 1'b0, 5'd31, 16'd8,  4'd15, 1'b1};
		rows[4]  = '{"step_p3",     11'd3,   1'b0, 7'd10, 4'd1, 1'b0, 5'd0,  16'd40, 4'd5,  1'b1};
		rows[5]  = '{"step_p7",     11'd7,   1'b0, 7'd4,  4'd2, 1'b0, 5'd20, 16'd64, 4'd12, 1'b1};
		rows[6]  = '{"wrap_p1",     11'd1,   1'b0, 7'd3,  4'd1, 1'b0, 5'd28, 16'd16, 4'd11, 1'b1};
		rows[7]  = '{"lin_live",    11'd3,   1'b0, 7'd2,  4'd2, 1'b0, 5'd3,  16'd40, 4'd2,  1'b1};
		rows[8]  = '{"lin_runout",  11'd3,   1'b0, 7'd2,  4'd3, 1'b0, 5'd3,  16'd40, 4'd12, 1'b1};
		rows[9]  = '{"ctrl_hold",   11'd3,   1'b1, 7'd2,  4'd3, 1'b0, 5'd0,  16'd40, 4'd5,  1'b0};
		rows[10] = '{"lock_freeze", 11'd3,   1'b0, 7'd5,  4'd1, 1'b1, 5'd9,  16'd40, 4'd6,  1'b1};
	endtask

	// Reset, writes, lfo pulses, settling and run per row, plus 10 percent
	function automatic int cycle_budget();
		int      total;
		int      i;
		period_t prev;
		total = 8;
		prev  = '0;
		for (i = 0; i < $size(rows); i++) begin
			total += 12 + 4 * rows[i].lfo_pulses + prev + rows[i].period + rows[i].run_cycles;
			prev = rows[i].period;
		end
		return total * 11 / 10;
	endfunction

	task automatic check_level(input logic [95:0] test_name, input tri_level_t expected,
			input tri_level_t actual);
		if (actual !== expected) begin
			$display("Fail %0s: tri_out expected 0x%h, got 0x%h", test_name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic check_flag(input logic [95:0] test_name, input string sig_name,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Fail %0s: %s expected 0x%h, got 0x%h", test_name, sig_name, expected, actual);
			test_ok = 1'b0;
		end
	endtask

	task automatic report_test(input logic [95:0] test_name);
		if (test_ok) begin
			pass_count++;
			$display("%0s: ok", test_name);
		end else begin
			fail_count++;
			$display("%0s: mismatch", test_name);
		end
	endtask

	task automatic apply_row(input row_t r, input period_t prev_period);
		reg_data_u b;
		b = '0;
		@(posedge phi1);  // Step frozen while the channel is set up
		lock    <= 1'b1;
		wr_step <= 1'b1;
		data    <= {3'b000, r.preset};
		@(posedge phi1);
		b.lin.ctrl   = r.ctrl;
		b.lin.reload = r.reload;
		wr_step <= 1'b0;
		wr_lin  <= 1'b1;
		data    <= b;
		@(posedge phi1);
		wr_lin <= 1'b0;
		wr_lo  <= 1'b1;
		data   <= r.period[7:0];
		@(posedge phi1);
		b.hi.length_idx = 5'h1f;
		b.hi.period_hi  = r.period[10:8];
		wr_lo <= 1'b0;
		wr_hi <= 1'b1;
		data  <= b;
		@(posedge phi1);
		wr_hi <= 1'b0;
		data  <= '0;
		repeat (r.lfo_pulses) begin
			@(posedge phi1);
			lfo <= 1'b1;
			@(posedge phi1);
			lfo <= 1'b0;
			repeat (2) @(posedge phi1);
		end
		// New period only loads at the next zero of the old count
		repeat (prev_period + r.period + 4) @(posedge phi1);
		@(posedge phi1);
		lock <= r.lock;
		repeat (r.run_cycles) @(posedge phi1);
		@(negedge phi1);
	endtask

	initial begin
		period_t prev_period;
		int      i;
		phi1       = 1'b0;
		arst_n     = 1'b0;
		wr_lin     = 1'b0;
		wr_lo      = 1'b0;
		wr_hi      = 1'b0;
		wr_step    = 1'b0;
		lfo        = 1'b0;
		lock       = 1'b0;
		data       = '0;
		pass_count = 0;
		fail_count = 0;
		fill_table();
		cycle_limit = cycle_budget();

		repeat (3) @(posedge phi1);
		arst_n <= 1'b1;
		@(negedge phi1);
		test_ok = 1'b1;
		check_level("reset", 4'hf, tri_out);
		check_flag("reset", "length_enable", 1'b1, length_enable);
		report_test("reset");

		prev_period = '0;
		for (i = 0; i < $size(rows); i++) begin
			apply_row(rows[i], prev_period);
			test_ok = 1'b1;
			check_level(rows[i].name, rows[i].exp_level, tri_out);
			check_flag(rows[i].name, "length_enable", rows[i].exp_len_en, length_enable);
			report_test(rows[i].name);
			prev_period = rows[i].period;
		end

		assert_fails = i_tri_chan.i_sequencer.i_seq_assert.fail_count;
		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			pass_count, fail_count, assert_fails);
		if (fail_count == 0 && assert_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	always @(posedge phi1) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Run timed out after %0d cycles without finishing", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

endmodule

/* flist.f */
logic/tri_pkg.sv
logic/tri_linear_counter.sv
logic/tri_period_timer.sv
logic/tri_sequencer.sv
logic/tri_chan.sv
verification/tri_chan_assert.sv
verification/tri_chan_tb.sv
